// File: design/day_night_fsm.sv
`timescale 1ns/1ps

module day_night_fsm (
    input  logic clk,
    input  logic reset,
    input  logic frame_end,
    output logic night
);
    import scene_pkg::*;

    sky_state_t state;
    sky_state_t state_next;
    logic [$clog2(NIGHT_FRAMES + 1) - 1:0] frame_cnt;

    always_comb begin
        state_next = state;
        case (state)
            DAY: begin
                if (frame_end && (int'(frame_cnt) == NIGHT_FRAMES - 1)) begin
                    state_next = NIGHT;
                end
            end
            NIGHT: state_next = NIGHT;
            default: state_next = DAY;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= DAY;
            frame_cnt <= '0;
        end else begin
            state <= state_next;
            // Frames only matter while still day
            if ((state == DAY) && frame_end) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    assign night = (state == NIGHT);

    a_night_is_final: assert property (
        @(posedge clk) disable iff (reset)
        night |=> night
    );

endmodule

// File: design/digit_overlay.sv
`timescale 1ns/1ps

module digit_overlay (
    input  display_pkg::pixel_pos_t pos,
    input  scene_pkg::score_regs_t  score,
    output logic                    digit_hit
);
    import display_pkg::*;

    logic [DIGIT_SIZE * DIGIT_SIZE - 1:0] glyph;
    hpos_t                                rel_h;
    vpos_t                                rel_v;
    logic                                 in_cell;
    logic [$clog2(DIGIT_SIZE) - 1:0]      row;
    logic [$clog2(DIGIT_SIZE) - 1:0]      col;

    // Font ROM with the top row in the high byte
    always_comb begin
        case (score.digit)
            4'd0: glyph = 64'h3C66_6E7E_7666_3C00;
            4'd1: glyph = 64'h1838_1818_1818_7E00;
            4'd2: glyph = 64'h3C66_061C_3066_7E00;
            4'd3: glyph = 64'h3C66_061C_0666_3C00;
            4'd4: glyph = 64'h0C1C_2C4C_7E0C_0C00;
            4'd5: glyph = 64'h7E60_7C06_0666_3C00;
            4'd6: glyph = 64'h3C66_607C_6666_3C00;
            4'd7: glyph = 64'h7E06_0C18_3030_3000;
            4'd8: glyph = 64'h3C66_663C_6666_3C00;
            4'd9: glyph = 64'h3C66_663E_0666_3C00;
            default: glyph = '0;
        endcase
    end

    assign rel_h = pos.h - score.x;
    assign rel_v = pos.v - score.y;

    // Lower bounds guard against the subtraction wrapping
    assign in_cell = (pos.h >= score.x) && (rel_h < hpos_t'(DIGIT_SIZE)) &&
                     (pos.v >= score.y) && (rel_v < vpos_t'(DIGIT_SIZE));

    assign row = rel_v[$clog2(DIGIT_SIZE) - 1:0];
    assign col = rel_h[$clog2(DIGIT_SIZE) - 1:0];

    // Leftmost pixel is the MSB of the row byte
    assign digit_hit = in_cell &&
        glyph[DIGIT_SIZE * DIGIT_SIZE - 1 - DIGIT_SIZE * int'(row) - int'(col)];

endmodule

// File: design/dino_scene.sv
`timescale 1ns/1ps

module dino_scene (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] writedata,
    input  logic        write,
    input  logic        chipselect,
    input  logic [8:0]  address,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        vga_sync_n
);
    import display_pkg::*;
    import scene_pkg::*;

    pixel_pos_t  pos;
    logic        active;
    logic        hs_n;
    logic        vs_n;
    logic        frame_end;
    logic        night;
    logic        digit_hit;
    score_regs_t score;

    vga_timing vga_timing_i (
        .clk       (clk),
        .reset     (reset),
        .pos       (pos),
        .active    (active),
        .hs_n      (hs_n),
        .vs_n      (vs_n),
        .frame_end (frame_end)
    );

    day_night_fsm day_night_fsm_i (
        .clk       (clk),
        .reset     (reset),
        .frame_end (frame_end),
        .night     (night)
    );

    scene_regs scene_regs_i (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .score      (score)
    );

    digit_overlay digit_overlay_i (
        .pos       (pos),
        .score     (score),
        .digit_hit (digit_hit)
    );

    pixel_painter pixel_painter_i (
        .clk         (clk),
        .reset       (reset),
        .pos         (pos),
        .active      (active),
        .hs_n        (hs_n),
        .vs_n        (vs_n),
        .night       (night),
        .digit_hit   (digit_hit),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    // Pixel clock toggles every other clock
    assign vga_clk    = pos.h[0];
    assign vga_sync_n = 1'b0;

endmodule

// File: design/display_pkg.sv
package display_pkg;

    // Horizontal timing in clocks with two clocks per pixel
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef logic [10:0] hpos_t;
    typedef logic [9:0]  vpos_t;

    typedef struct packed {
        hpos_t h;
        vpos_t v;
    } pixel_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Background band boundaries
    localparam int SKY_LINE   = 280;
    localparam int STRIPE_END = 300;

    localparam rgb_t DAY_SKY      = '{r: 8'd135, g: 8'd206, b: 8'd235};
    localparam rgb_t NIGHT_SKY    = '{r: 8'd10,  g: 8'd10,  b: 8'd40};
    localparam rgb_t STRIPE_COLOR = '{r: 8'd100, g: 8'd40,  b: 8'd10};
    localparam rgb_t GROUND_COLOR = '{r: 8'd139, g: 8'd69,  b: 8'd19};
    localparam rgb_t LINE_COLOR   = '{r: 8'd0,   g: 8'd0,   b: 8'd0};
    localparam rgb_t DIGIT_COLOR  = '{r: 8'd0,   g: 8'd0,   b: 8'd0};

    localparam int DIGIT_SIZE = 8;

endpackage

// File: design/pixel_painter.sv
`timescale 1ns/1ps

module pixel_painter (
    input  logic                    clk,
    input  logic                    reset,
    input  display_pkg::pixel_pos_t pos,
    input  logic                    active,
    input  logic                    hs_n,
    input  logic                    vs_n,
    input  logic                    night,
    input  logic                    digit_hit,
    output logic [7:0]              vga_r,
    output logic [7:0]              vga_g,
    output logic [7:0]              vga_b,
    output logic                    vga_hs,
    output logic                    vga_vs,
    output logic                    vga_blank_n
);
    import display_pkg::*;

    rgb_t color;

    always_comb begin
        if (pos.v < vpos_t'(SKY_LINE)) begin
            color = night ? NIGHT_SKY : DAY_SKY;
        end else if (pos.v == vpos_t'(SKY_LINE)) begin
            color = LINE_COLOR;
        end else if (pos.v <= vpos_t'(STRIPE_END)) begin
            color = STRIPE_COLOR;
        end else begin
            color = GROUND_COLOR;
        end

        // Score digit drawn over the bands
        if (digit_hit) begin
            color = DIGIT_COLOR;
        end

        if (!active) begin
            color = '0;
        end
    end

    // One register stage keeps colour and syncs aligned
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_r       <= color.r;
            vga_g       <= color.g;
            vga_b       <= color.b;
            vga_hs      <= hs_n;
            vga_vs      <= vs_n;
            vga_blank_n <= active;
        end
    end

endmodule

// File: design/scene_pkg.sv
package scene_pkg;

    // Register map on the 9-bit bus
    localparam logic [8:0] ADDR_SCORE   = 9'd0;
    localparam logic [8:0] ADDR_SCORE_X = 9'd1;
    localparam logic [8:0] ADDR_SCORE_Y = 9'd2;

    localparam int MAX_DIGIT = 9;

    typedef struct packed {
        logic [3:0]         digit;
        display_pkg::hpos_t x;
        display_pkg::vpos_t y;
    } score_regs_t;

    localparam score_regs_t SCORE_RESET = '{
        digit: 4'd0,
        x:     11'd25,
        y:     10'd41
    };

    typedef enum logic {
        DAY,
        NIGHT
    } sky_state_t;

    // Completed frames before the sky turns dark
    localparam int NIGHT_FRAMES = 2;

endpackage

// File: design/scene_regs.sv
`timescale 1ns/1ps

module scene_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   chipselect,
    input  logic                   write,
    input  logic [8:0]             address,
    input  logic [31:0]            writedata,
    output scene_pkg::score_regs_t score
);
    import display_pkg::*;
    import scene_pkg::*;

    logic bus_write;
    logic digit_ok;

    assign bus_write = chipselect && write;

    // Only digits with a glyph are taken
    assign digit_ok = (writedata <= 32'(MAX_DIGIT));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= SCORE_RESET;
        end else if (bus_write) begin
            case (address)
                ADDR_SCORE: begin
                    if (digit_ok) begin
                        score.digit <= writedata[3:0];
                    end
                end
                ADDR_SCORE_X: score.x <= hpos_t'(writedata);
                ADDR_SCORE_Y: score.y <= vpos_t'(writedata);
                default: ;
            endcase
        end
    end

    a_digit_in_range: assert property (
        @(posedge clk) disable iff (reset)
        score.digit <= 4'(MAX_DIGIT)
    );

endmodule

// File: design/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic                    clk,
    input  logic                    reset,
    output display_pkg::pixel_pos_t pos,
    output logic                    active,
    output logic                    hs_n,
    output logic                    vs_n,
    output logic                    frame_end
);
    import display_pkg::*;

    logic line_end;
    logic field_end;

    assign line_end  = (pos.h == hpos_t'(H_TOTAL - 1));
    assign field_end = (pos.v == vpos_t'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos <= '0;
        end else if (line_end) begin
            pos.h <= '0;
            if (field_end) begin
                pos.v <= '0;
            end else begin
                pos.v <= pos.v + 1'b1;
            end
        end else begin
            pos.h <= pos.h + 1'b1;
        end
    end

    // Sync pulses sit between front and back porch
    assign hs_n = !((pos.h >= hpos_t'(H_ACTIVE + H_FRONT)) &&
                    (pos.h <  hpos_t'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vs_n = !((pos.v >= vpos_t'(V_ACTIVE + V_FRONT)) &&
                    (pos.v <  vpos_t'(V_ACTIVE + V_FRONT + V_SYNC)));

    assign active    = (pos.h < hpos_t'(H_ACTIVE)) && (pos.v < vpos_t'(V_ACTIVE));
    assign frame_end = line_end && field_end;

    a_pos_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (pos.h < hpos_t'(H_TOTAL)) && (pos.v < vpos_t'(V_TOTAL))
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the dino_scene testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dino_scene_tb -f src.f \
    --Mdir obj_dir -o dino_scene_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dino_scene_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// File: src.f
design/display_pkg.sv
design/scene_pkg.sv
design/vga_timing.sv
design/day_night_fsm.sv
design/scene_regs.sv
design/digit_overlay.sv
design/pixel_painter.sv
design/dino_scene.sv
verification/dino_scene_tb.sv

// File: verification/dino_scene_tb.sv
`timescale 1ns/1ps

module dino_scene_tb;
    import display_pkg::*;
    import scene_pkg::*;

    // Four frames plus margin cover the three that the tests use
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 140000;

    localparam int HS_FIRST = 1312;
    localparam int HS_LAST  = 1503;
    localparam int VS_FIRST = 490;
    localparam int VS_LAST  = 491;

    // One byte per glyph row with the leftmost pixel in bit 7
    localparam logic [7:0] FONT [0:79] = '{
        8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00,
        8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00,
        8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00,
        8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00,
        8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00,
        8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00,
        8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00,
        8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00,
        8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00,
        8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00
    };

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] writedata;
    logic        write;
    logic        chipselect;
    logic [8:0]  address;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;

    // Raster counter mirror and the pixel shown at the outputs
    int   pos_h = 0;
    int   pos_v = 0;
    int   pos_frame = 0;
    int   out_h = 0;
    int   out_v = 0;
    int   out_frame = 0;
    logic out_valid = 1'b0;

    int error_count = 0;
    int cycle_count = 0;

    // Expected score register contents
    int model_digit = 0;
    int model_x = 25;
    int model_y = 41;

    dino_scene dino_scene_i (
        .clk         (clk),
        .reset       (reset),
        .writedata   (writedata),
        .write       (write),
        .chipselect  (chipselect),
        .address     (address),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            pos_h     <= 0;
            pos_v     <= 0;
            pos_frame <= 0;
            out_valid <= 1'b0;
        end else begin
            out_h     <= pos_h;
            out_v     <= pos_v;
            out_frame <= pos_frame;
            out_valid <= 1'b1;
            if (pos_h == H_TOTAL - 1) begin
                pos_h <= 0;
                if (pos_v == V_TOTAL - 1) begin
                    pos_v     <= 0;
                    pos_frame <= pos_frame + 1;
                end else begin
                    pos_v <= pos_v + 1;
                end
            end else begin
                pos_h <= pos_h + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d", error_count + 1);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    function automatic longint pixel_index(input int frame, input int h, input int v);
        return longint'(frame) * FRAME_CYCLES + longint'(v) * H_TOTAL + h;
    endfunction

    function automatic longint shown_index();
        if (!out_valid) begin
            return -1;
        end
        return pixel_index(out_frame, out_h, out_v);
    endfunction

    // Returns on a falling edge where the outputs show (h, v) of the frame
    task automatic wait_pixel(input int frame, input int h, input int v);
        longint target;
        target = pixel_index(frame, h, v);
        while (shown_index() < target) begin
            @(negedge clk);
        end
        if (shown_index() > target) begin
            error_count++;
            $display("Pixel (%0d,%0d) of frame %0d had already gone by", h, v, frame);
        end
    endtask

    function automatic rgb_t expected_rgb(input int h, input int v, input int frame);
        rgb_t       c;
        logic [7:0] row_bits;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return '0;
        end
        if (v < SKY_LINE) begin
            c = (frame >= NIGHT_FRAMES) ? NIGHT_SKY : DAY_SKY;
        end else if (v == SKY_LINE) begin
            c = LINE_COLOR;
        end else if (v <= STRIPE_END) begin
            c = STRIPE_COLOR;
        end else begin
            c = GROUND_COLOR;
        end
        if (h >= model_x && h < model_x + DIGIT_SIZE &&
            v >= model_y && v < model_y + DIGIT_SIZE) begin
            row_bits = FONT[model_digit * DIGIT_SIZE + (v - model_y)];
            if (row_bits[7 - (h - model_x)]) begin
                c = DIGIT_COLOR;
            end
        end
        return c;
    endfunction

    task automatic write_register(input logic [8:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #2;
        chipselect = 1'b0;
        write      = 1'b0;
        case (addr)
            9'd0: begin
                if (data <= 32'd9) begin
                    model_digit = int'(data[3:0]);
                end
            end
            9'd1: model_x = int'(data[10:0]);
            9'd2: model_y = int'(data[9:0]);
            default: ;
        endcase
    endtask

    task automatic check_sync_signals(input int h, input int v);
        string where;
        where = $sformatf("at (%0d,%0d)", h, v);
        check_value({"timing vga_hs ", where}, !(h >= HS_FIRST && h <= HS_LAST), vga_hs);
        check_value({"timing vga_vs ", where}, !(v >= VS_FIRST && v <= VS_LAST), vga_vs);
        check_value({"timing vga_blank_n ", where}, (h < H_ACTIVE) && (v < V_ACTIVE),
                    vga_blank_n);
        // vga_clk follows the raster counter one pixel ahead of the outputs
        check_value({"timing vga_clk ", where}, pos_h % 2, vga_clk);
        check_value({"timing vga_sync_n ", where}, 0, vga_sync_n);
    endtask

    task automatic scan_digit_cell(input string name, input int frame);
        for (int r = 0; r < DIGIT_SIZE; r++) begin
            for (int c = 0; c < DIGIT_SIZE; c++) begin
                wait_pixel(frame, model_x + c, model_y + r);
                check_value($sformatf("%s cell (%0d,%0d)", name, c, r),
                            expected_rgb(model_x + c, model_y + r, frame),
                            {vga_r, vga_g, vga_b});
            end
        end
    endtask

    task automatic check_bands(input string name, input int frame, input rgb_t sky);
        int   rows [4] = '{100, 280, 290, 400};
        int   cols [7] = '{0, 320, 640, 1279, 1280, 1400, 1599};
        rgb_t bands [4];
        bands = '{sky, LINE_COLOR, STRIPE_COLOR, GROUND_COLOR};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 7; j++) begin
                wait_pixel(frame, cols[j], rows[i]);
                check_value($sformatf("%s rgb at (%0d,%0d)", name, cols[j], rows[i]),
                            (cols[j] < H_ACTIVE) ? bands[i] : '0, {vga_r, vga_g, vga_b});
                check_value($sformatf("%s blank_n at (%0d,%0d)", name, cols[j], rows[i]),
                            cols[j] < H_ACTIVE, vga_blank_n);
            end
        end
    endtask

    task automatic test_timing();
        check_value("timing reset rgb", 0, {vga_r, vga_g, vga_b});
        check_value("timing reset vga_blank_n", 0, vga_blank_n);
        check_value("timing reset vga_hs", 1, vga_hs);
        check_value("timing reset vga_vs", 1, vga_vs);
        for (int h = 0; h < H_TOTAL; h++) begin
            wait_pixel(0, h, 0);
            check_sync_signals(h, 0);
        end
        for (int v = VS_FIRST - 2; v <= VS_LAST + 2; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                wait_pixel(0, h, v);
                check_sync_signals(h, v);
            end
        end
    endtask

    task automatic test_score_overlay();
        int digit;
        int x;
        int y;
        digit = $urandom_range(9, 0);
        x = $urandom_range(H_ACTIVE - DIGIT_SIZE, 0);
        // Cell stays above the rows that the band tests sample
        y = $urandom_range(88, 0);
        write_register(ADDR_SCORE, 32'(digit));
        write_register(ADDR_SCORE_X, 32'(x));
        write_register(ADDR_SCORE_Y, 32'(y));
        scan_digit_cell("score_overlay", 1);
    endtask

    task automatic test_day_background();
        check_bands("day_background", 1, DAY_SKY);
    endtask

    task automatic test_ignored_writes();
        int kept;
        kept = model_digit;
        write_register(ADDR_SCORE, 32'd12);
        write_register(9'd3, $urandom());
        // Would alias the score register if the upper address bit were dropped
        write_register(9'h100, 32'((kept + 1) % 10));
        scan_digit_cell("ignored_writes", 2);
    endtask

    task automatic test_night();
        check_bands("night", 2, NIGHT_SKY);
    endtask

    initial begin
        void'($urandom(27));
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        test_timing();
        test_score_overlay();
        test_day_background();
        test_ignored_writes();
        test_night();

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
